/* hw/async_fifo.sv */
// Dual-clock FIFO with type-parameter payload, Gray pointer crossing and flush
`timescale 1ns/1ps

module async_fifo
	import cdc_pkg::*;
#(
	parameter type T = logic
) (
	input logic wr_clock,
	input logic rd_clock,
	input logic inRESET,
	input logic remove,
	fifo_if.fifo port
);

	// Entry storage
	T mem [FIFO_DEPTH];

	// Write domain pointers
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] wr_ptr_next;
	logic [PTR_W-1:0] wr_gray;
	// Read pointer as seen in the write domain
	logic [PTR_W-1:0] rd_ptr_wside;

	// Read domain pointers
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_ptr_next;
	logic [PTR_W-1:0] rd_gray;
	// Write pointer as seen in the read domain
	logic [PTR_W-1:0] wr_ptr_rside;

	logic push;
	logic pop;

	// Accepted transfers only
	assign push = port.wr_en && !port.full;
	assign pop = port.rd_en && !port.empty;

	assign wr_ptr_next = wr_ptr + 1'b1;
	assign rd_ptr_next = rd_ptr + 1'b1;

	// Write pointer
	// Gray copy is registered with the binary one, so no glitch reaches the other clock
	always_ff @(posedge wr_clock or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			wr_gray <= '0;
		end else if (remove) begin
			wr_ptr <= '0;
			wr_gray <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr_next;
			wr_gray <= bin2gray(wr_ptr_next);
		end
	end

	// Storage write
	always_ff @(posedge wr_clock) begin
		if (push && !remove) begin
			mem[wr_ptr[FIFO_DEPTH_LOG-1:0]] <= port.wr_data;
		end
	end

	// Read pointer
	always_ff @(posedge rd_clock or negedge inRESET) begin
		if (!inRESET) begin
			rd_ptr <= '0;
			rd_gray <= '0;
		end else if (remove) begin
			rd_ptr <= '0;
			rd_gray <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr_next;
			rd_gray <= bin2gray(rd_ptr_next);
		end
	end

	// Freed slots reach the writer after two write clocks
	gray_sync rd_to_wr (
		.iCLOCK(wr_clock),
		.inRESET(inRESET),
		.gray_in(rd_gray),
		.bin_out(rd_ptr_wside)
	);

	// New entries reach the reader after two read clocks
	gray_sync wr_to_rd (
		.iCLOCK(rd_clock),
		.inRESET(inRESET),
		.gray_in(wr_gray),
		.bin_out(wr_ptr_rside)
	);

	// Full when the writer is a whole depth ahead
	assign port.full = ((wr_ptr - rd_ptr_wside) == PTR_W'(FIFO_DEPTH));
	// Empty when the reader has caught up
	assign port.empty = (rd_ptr == wr_ptr_rside);

	// Head entry, valid while empty is low
	assign port.rd_data = mem[rd_ptr[FIFO_DEPTH_LOG-1:0]];

endmodule

/* hw/cdc_bridge_top.sv */
// Bridge top level: core stage, command FIFO, device stage, response FIFO
`timescale 1ns/1ps

module cdc_bridge_top
	import cdc_pkg::*;
(
	input logic iCLOCK,
	input logic dev_clock,
	input logic inRESET,
	input logic remove,
	// Core request side
	input logic req,
	input logic req_write,
	input logic [ADDR_W-1:0] req_addr,
	input logic [DATA_W-1:0] req_data,
	output logic busy,
	// Core response side
	output logic resp_valid,
	output logic [DATA_W-1:0] resp_data,
	output logic idle
);

	// Core to device
	fifo_if #(.T(cmd_t)) cmd_bus ();
	// Device to core
	fifo_if #(.T(resp_t)) resp_bus ();

	core_req_stage core0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.remove(remove),
		.req(req),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_data(req_data),
		.busy(busy),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.idle(idle),
		.cmd(cmd_bus.writer),
		.rsp(resp_bus.reader)
	);

	// Written on iCLOCK, read on dev_clock
	async_fifo #(.T(cmd_t)) cmd_fifo (
		.wr_clock(iCLOCK),
		.rd_clock(dev_clock),
		.inRESET(inRESET),
		.remove(remove),
		.port(cmd_bus.fifo)
	);

	dev_exec_stage dev0 (
		.dev_clock(dev_clock),
		.inRESET(inRESET),
		.remove(remove),
		.cmd(cmd_bus.reader),
		.rsp(resp_bus.writer)
	);

	// Written on dev_clock, read on iCLOCK
	async_fifo #(.T(resp_t)) resp_fifo (
		.wr_clock(dev_clock),
		.rd_clock(iCLOCK),
		.inRESET(inRESET),
		.remove(remove),
		.port(resp_bus.fifo)
	);

endmodule

/* hw/cdc_pkg.sv */
// Bridge widths, FIFO depth, command and response types, Gray pointer conversion functions
package cdc_pkg;

	// Register bank geometry
	localparam int DATA_W = 32;
	localparam int ADDR_W = 4;
	localparam int REG_COUNT = 16;

	// Both FIFOs hold 2**FIFO_DEPTH_LOG entries
	localparam int FIFO_DEPTH_LOG = 2;
	localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG;
	// Pointer has one wrap bit above the slot index
	localparam int PTR_W = FIFO_DEPTH_LOG + 1;

	// Outstanding read counter, covers both FIFOs plus the output register
	localparam int OUTST_W = 4;

	// One core request as seen by the device, 37 bits
	typedef struct packed {
		logic write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} cmd_t;

	// Read result travelling back to the core
	typedef struct packed {
		logic [DATA_W-1:0] data;
	} resp_t;

	// Adjacent values differ in one bit only
	function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// MSB passes through, each lower bit folds in the bits above
	function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] gray);
		logic [PTR_W-1:0] bin;
		bin[PTR_W-1] = gray[PTR_W-1];
		for (int i = PTR_W - 2; i >= 0; i--) begin
			bin[i] = gray[i] ^ bin[i+1];
		end
		return bin;
	endfunction

endpackage

/* hw/core_req_stage.sv */
// Core-side stage: request packing, outstanding read count, response pulse, idle status
`timescale 1ns/1ps

module core_req_stage
	import cdc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic req,
	input logic req_write,
	input logic [ADDR_W-1:0] req_addr,
	input logic [DATA_W-1:0] req_data,
	output logic busy,
	output logic resp_valid,
	output logic [DATA_W-1:0] resp_data,
	output logic idle,
	fifo_if.writer cmd,
	fifo_if.reader rsp
);

	cmd_t req_cmd;
	resp_t rsp_head;
	logic accept;
	logic read_accept;
	logic pop;
	logic [OUTST_W-1:0] outstanding;
	// Command FIFO empty, brought over from the device clock
	logic cmd_empty_meta;
	logic cmd_empty_sync;

	// Core stalls while the command FIFO is full
	assign busy = cmd.full;
	assign accept = req && !cmd.full;
	// Reads issued during a flush are lost with the FIFO contents
	assign read_accept = accept && !req_write && !remove;

	// Push straight from the request, no staging register
	assign req_cmd.write = req_write;
	assign req_cmd.addr = req_addr;
	assign req_cmd.data = req_data;
	assign cmd.wr_en = accept;
	assign cmd.wr_data = req_cmd;

	// Drain responses one per cycle
	assign pop = !rsp.empty && !remove;
	assign rsp.rd_en = pop;
	assign rsp_head = rsp.rd_data;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= pop;
		end
	end

	// Data held until the next pop
	always_ff @(posedge iCLOCK) begin
		if (pop) begin
			resp_data <= rsp_head.data;
		end
	end

	// Up on an accepted read, down on a delivered pulse
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			outstanding <= '0;
		end else if (remove) begin
			outstanding <= '0;
		end else if (read_accept && !resp_valid) begin
			outstanding <= outstanding + 1'b1;
		end else if (!read_accept && resp_valid) begin
			outstanding <= outstanding - 1'b1;
		end
	end

	// Reset high so idle holds right after reset
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cmd_empty_meta <= 1'b1;
			cmd_empty_sync <= 1'b1;
		end else begin
			cmd_empty_meta <= cmd.empty;
			cmd_empty_sync <= cmd_empty_meta;
		end
	end

	assign idle = (outstanding == '0) && cmd_empty_sync;

endmodule

/* hw/dev_exec_stage.sv */
// Device-side stage: command execution on the register bank, read results to the response FIFO
`timescale 1ns/1ps

module dev_exec_stage
	import cdc_pkg::*;
(
	input logic dev_clock,
	input logic inRESET,
	input logic remove,
	fifo_if.reader cmd,
	fifo_if.writer rsp
);

	// Peripheral registers
	logic [DATA_W-1:0] regs [REG_COUNT];

	cmd_t head;
	resp_t result;
	logic head_valid;
	logic read_blocked;
	logic step;
	logic do_write;
	logic do_read;

	// Head command, meaningful only while the FIFO is not empty
	assign head = cmd.rd_data;

	// Nothing runs during a flush
	assign head_valid = !cmd.empty && !remove;

	// A read needs room for its result
	// Commands behind it wait too, so order holds
	assign read_blocked = !head.write && rsp.full;

	// One command per cycle
	assign step = head_valid && !read_blocked;
	assign do_write = step && head.write;
	assign do_read = step && !head.write;

	assign cmd.rd_en = step;

	// Result goes out on the same edge as the pop
	assign result.data = regs[head.addr];
	assign rsp.wr_en = do_read;
	assign rsp.wr_data = result;

	// Bank survives a flush, only reset clears it
	always_ff @(posedge dev_clock or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (do_write) begin
			regs[head.addr] <= head.data;
		end
	end

endmodule

/* hw/fifo_if.sv */
// FIFO interface with writer, FIFO and reader modports
`timescale 1ns/1ps

interface fifo_if #(
	parameter type T = logic
);

	// Write side, lives in the write clock domain
	logic wr_en;
	T wr_data;
	logic full;

	// Read side, lives in the read clock domain
	logic rd_en;
	T rd_data;
	logic empty;

	// Producer
	// empty is a read-domain level, the writer must synchronize it before use
	modport writer (output wr_en, output wr_data, input full, input empty);

	// The FIFO itself
	modport fifo (
		input wr_en,
		input wr_data,
		input rd_en,
		output full,
		output empty,
		output rd_data
	);

	// Consumer
	modport reader (output rd_en, input rd_data, input empty);

endinterface

/* hw/gray_sync.sv */
// Two-stage synchronizer for a Gray-coded FIFO pointer with binary output
`timescale 1ns/1ps

module gray_sync
	import cdc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic [FIFO_DEPTH_LOG:0] gray_in,
	output logic [FIFO_DEPTH_LOG:0] bin_out
);

	// First stage may go metastable
	logic [FIFO_DEPTH_LOG:0] gray_meta;
	// Second stage is safe to decode
	logic [FIFO_DEPTH_LOG:0] gray_sync_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			gray_meta <= '0;
			gray_sync_q <= '0;
		end else begin
			gray_meta <= gray_in;
			gray_sync_q <= gray_meta;
		end
	end

	// Decode only after both stages
	assign bin_out = gray2bin(gray_sync_q);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_cdc_bridge -o tb_cdc_bridge
if ! ./obj_dir/tb_cdc_bridge +verilator+error+limit+1000 > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi
cat sim.log
if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* tb.f */
hw/cdc_pkg.sv
hw/fifo_if.sv
hw/gray_sync.sv
hw/async_fifo.sv
hw/core_req_stage.sv
hw/dev_exec_stage.sv
hw/cdc_bridge_top.sv
tests/cdc_bridge_asserts.sv
tests/tb_cdc_bridge.sv

/* tests/cdc_bridge_asserts.sv */
// Port-level assertions for the bridge: startup outputs, response accounting, busy release
`timescale 1ns/1ps

module cdc_bridge_asserts
	import cdc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic req,
	input logic req_write,
	input logic busy,
	input logic resp_valid,
	input logic idle
);

	// Number of failed assertions
	int unsigned fail_count = 0;

	logic [3:0] since_reset;
	// Accepted reads minus delivered pulses
	logic [7:0] shadow;
	// Cycles with busy high and req low
	logic [7:0] busy_wait;
	logic read_acc;

	assign read_acc = req && !busy && !req_write && !remove;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			since_reset <= '0;
			shadow <= '0;
			busy_wait <= '0;
		end else begin
			if (since_reset != 4'hf) begin
				since_reset <= since_reset + 4'd1;
			end
			// Flush forgets every pending read
			if (remove) begin
				shadow <= '0;
			end else begin
				shadow <= shadow + {7'd0, read_acc} - {7'd0, resp_valid};
			end
			if (req || !busy) begin
				busy_wait <= '0;
			end else if (busy_wait != 8'hff) begin
				busy_wait <= busy_wait + 8'd1;
			end
		end
	end

	// Outputs at rest for the first cycles out of reset
	startup_quiet: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(since_reset < 4'd8) |-> (!busy && !resp_valid && idle))
		else begin
			$error("busy, resp_valid or idle wrong right after reset");
			fail_count++;
		end

	// Every pulse answers a read still pending
	pulse_backed: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		resp_valid |-> (shadow != 8'd0))
		else begin
			$error("resp_valid with no read outstanding");
			fail_count++;
		end

	// Pending reads keep idle low
	idle_consistent: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(shadow != 8'd0) |-> !idle)
		else begin
			$error("idle high while reads are outstanding");
			fail_count++;
		end

	// Device drains the command FIFO once requests stop
	busy_release: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		busy_wait < 8'd40)
		else begin
			$error("busy stuck high after requests stopped");
			fail_count++;
		end

endmodule

/* tests/tb_cdc_bridge.sv */
// Bridge testbench: clocks, reset, LFSR stimulus, register bank model, watchdog, result line
`timescale 1ns/1ps

module tb_cdc_bridge
	import cdc_pkg::*;
();

	localparam int N_MIXED = 40;
	localparam int N_BURST = 16;
	localparam int N_FLUSH = 3;
	localparam int N_PAIRS = 6;
	localparam int PLANNED = N_MIXED + N_BURST + N_FLUSH + 2 * N_PAIRS + REG_COUNT;
	// 40 device clocks of 74 ns per request plus margin
	localparam int WATCHDOG_NS = PLANNED * 40 * 74 + 20000;

	logic iCLOCK = 1'b0;
	logic dev_clock = 1'b0;
	logic inRESET;
	logic remove;
	logic req;
	logic req_write;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_data;
	logic busy;
	logic resp_valid;
	logic [DATA_W-1:0] resp_data;
	logic idle;

	logic [31:0] lfsr_state = 32'hab7e;
	// Register bank copy and read data still owed
	logic [DATA_W-1:0] model_regs [REG_COUNT] = '{default: '0};
	logic [DATA_W-1:0] expect_q [$];
	int errors = 0;
	int checked = 0;
	logic saw_busy = 1'b0;

	always #20 iCLOCK = ~iCLOCK;
	// Odd half period keeps rising edges apart from iCLOCK rising edges
	always #37 dev_clock = ~dev_clock;

	cdc_bridge_top dut0 (
		.iCLOCK(iCLOCK), .dev_clock(dev_clock), .inRESET(inRESET), .remove(remove),
		.req(req), .req_write(req_write), .req_addr(req_addr), .req_data(req_data),
		.busy(busy), .resp_valid(resp_valid), .resp_data(resp_data), .idle(idle)
	);

	bind cdc_bridge_top cdc_bridge_asserts asserts0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .remove(remove), .req(req),
		.req_write(req_write), .busy(busy), .resp_valid(resp_valid),
		.idle(idle)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Held until an edge with busy low takes it
	task automatic issue(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data);
		req <= 1'b1;
		req_write <= wr;
		req_addr <= addr;
		req_data <= data;
		@(posedge iCLOCK);
		while (busy) begin
			@(posedge iCLOCK);
		end
	endtask

	// Writes executed before idle counts
	task automatic finish_traffic();
		req <= 1'b0;
		repeat (12) @(posedge iCLOCK);
		while (!idle) begin
			@(posedge iCLOCK);
		end
	endtask

	task automatic check_response();
		logic [DATA_W-1:0] expected;
		assert (expect_q.size() > 0) else begin
			$display("A response arrived at %0t with no read outstanding", $time);
			errors++;
		end
		if (expect_q.size() > 0) begin
			expected = expect_q.pop_front();
			checked++;
			assert (resp_data === expected) else begin
				$display("CHECK FAILED at %0t: resp_data %h, expected %h",
					$time, resp_data, expected);
				errors++;
			end
		end
	endtask

	// Device runs commands in order, so the copy answers reads at accept time
	always @(posedge iCLOCK) begin
		if (inRESET && remove) begin
			expect_q.delete();
		end else if (inRESET) begin
			if (resp_valid) begin
				check_response();
			end
			if (req && !busy && req_write) begin
				model_regs[req_addr] = req_data;
			end else if (req && !busy) begin
				expect_q.push_back(model_regs[req_addr]);
			end
			if (req && busy) begin
				saw_busy = 1'b1;
			end
		end
	end

	initial begin
		int total;
		logic wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		inRESET = 1'b0;
		remove = 1'b0;
		req = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_data = '0;
		repeat (3) @(posedge iCLOCK);
		inRESET <= 1'b1;
		// Startup window for the quiet-output check
		repeat (12) @(posedge iCLOCK);
		// Random mix with occasional idle cycles
		for (int i = 0; i < N_MIXED; i++) begin
			wr = 1'(take_bits(1));
			addr = ADDR_W'(take_bits(ADDR_W));
			data = take_bits(DATA_W);
			issue(wr, addr, data);
			if (2'(take_bits(2)) == 2'd0) begin
				req <= 1'b0;
				@(posedge iCLOCK);
			end
		end
		finish_traffic();
		// Back-to-back reads fill the command FIFO
		for (int i = 0; i < N_BURST; i++) begin
			issue(1'b0, ADDR_W'(take_bits(ADDR_W)), '0);
		end
		finish_traffic();
		// Reads caught in flight by a flush
		for (int i = 0; i < N_FLUSH; i++) begin
			issue(1'b0, ADDR_W'(take_bits(ADDR_W)), '0);
		end
		req <= 1'b0;
		remove <= 1'b1;
		// Longer than three device clocks
		repeat (8) @(posedge iCLOCK);
		remove <= 1'b0;
		repeat (12) @(posedge iCLOCK);
		for (int i = 0; i < N_PAIRS; i++) begin
			addr = ADDR_W'(take_bits(ADDR_W));
			data = take_bits(DATA_W);
			issue(1'b1, addr, data);
			issue(1'b0, addr, '0);
		end
		// Whole bank read back with older contents kept through the flush
		for (int a = 0; a < REG_COUNT; a++) begin
			issue(1'b0, ADDR_W'(a), '0);
		end
		finish_traffic();
		total = errors;
		assert (expect_q.size() == 0) else begin
			$display("%0d expected read results never arrived", expect_q.size());
			total++;
		end
		assert (saw_busy) else begin
			$display("The read burst never raised busy");
			total++;
		end
		total = total + int'(dut0.asserts0.fail_count);
		$display("Responses checked %0d, testbench errors %0d, assertion failures %0d",
			checked, total - int'(dut0.asserts0.fail_count), dut0.asserts0.fail_count);
		if (total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, traffic did not complete", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule
